// File: build.f
+incdir+common
common/mips_pkg.sv
execute/alu_control.sv
execute/alu.sv
execute/execute_stage.sv
src/pipe_reg.sv
src/ex_core.sv
tests/tb_ex_core.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the ex_core testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_ex_core \
    -f build.f \
    -o sim_ex_core

# The simulator exits non-zero on $fatal; the log decides the result.
./obj_dir/sim_ex_core > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "\*\* FAIL \*\*" "$LOG"; then
    echo "simulation failed"
    exit 1
fi

if ! grep -q "\*\* PASS \*\*" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"

// File: tests/tb_ex_core.sv
`timescale 1ns/1ns

`include "mips_cfg.svh"

module tb_ex_core;

    localparam int RESET_CYCLES = 3;
    localparam int N_RTYPE_EACH = 8;
    localparam int N_IMM_EACH   = 16;
    localparam int N_BEQ        = 20;
    localparam int N_MIX        = 220;
    localparam int N_DRAIN      = 4;
    localparam int TEST_CYCLES  = RESET_CYCLES + 7 * N_RTYPE_EACH + 3 * N_IMM_EACH
                                + N_BEQ + N_MIX + N_DRAIN + 2;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 250;

    // six valid function codes and one unknown one.
    localparam logic [`MIPS_NB_FUNC-1:0] FUNCT_TABLE [7] = '{
        6'h20, 6'h22, 6'h24, 6'h25, 6'h27, 6'h2a, 6'h3f
    };
    localparam logic [`MIPS_NB_OP-1:0] IMM_OPS [3] = '{2'b00, 2'b01, 2'b11};

    // alu operations of the reference model.
    localparam int K_ADD = 0;
    localparam int K_SUB = 1;
    localparam int K_AND = 2;
    localparam int K_OR  = 3;
    localparam int K_NOR = 4;
    localparam int K_SLT = 5;

    logic              i_clk = 1'b0;
    logic              i_rst;
    logic              i_stall;
    logic              i_flush;
    mips_pkg::id_ex_t  i_id_ex;
    mips_pkg::ex_mem_t o_ex_mem;

    // expected contents of the id/ex and ex/mem registers.
    mips_pkg::ex_mem_t exp_stage;
    mips_pkg::ex_mem_t exp_out;

    integer seed;
    int     cycle_count = 0;
    int     valid_seen = 0;
    int     fail_count = 0;

    ex_core dut_i (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_stall  (i_stall),
        .i_flush  (i_flush),
        .i_id_ex  (i_id_ex),
        .o_ex_mem (o_ex_mem)
    );

    initial begin
        forever #10 i_clk = ~i_clk;
    end

    task automatic report_error(input string msg);
        fail_count++;
        $display("Error: %0t ns: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    // ############################################################
    // reference model.
    // ############################################################

    function automatic mips_pkg::ex_mem_t expected_result(input mips_pkg::id_ex_t d);
        mips_pkg::ex_mem_t e;
        logic [`MIPS_NB_DATA-1:0] b;
        logic [`MIPS_NB_DATA-1:0] res;
        int kind;
        e = '0;
        if (!d.valid) begin
            return e;
        end
        b = d.ex.alu_src ? d.imm : d.read_data_2;
        case (d.ex.alu_op)
            2'b00: kind = K_ADD;
            2'b01: kind = K_SUB;
            2'b11: kind = K_SLT;
            default: begin
                case (d.imm[5:0])
                    6'h22:   kind = K_SUB;
                    6'h24:   kind = K_AND;
                    6'h25:   kind = K_OR;
                    6'h27:   kind = K_NOR;
                    6'h2a:   kind = K_SLT;
                    default: kind = K_ADD;
                endcase
            end
        endcase
        case (kind)
            K_SUB:   res = d.read_data_1 - b;
            K_AND:   res = d.read_data_1 & b;
            K_OR:    res = d.read_data_1 | b;
            K_NOR:   res = ~(d.read_data_1 | b);
            K_SLT:   res = ($signed(d.read_data_1) < $signed(b)) ? 32'd1 : 32'd0;
            default: res = d.read_data_1 + b;
        endcase
        e.valid         = 1'b1;
        e.branch_target = d.pc_next + (d.imm << 2);
        e.alu_result    = res;
        e.zero          = (res == '0);
        e.store_data    = d.read_data_2;
        e.write_reg     = d.ex.reg_dst ? d.rd : d.rt;
        e.mem           = d.mem;
        e.wb            = d.wb;
        return e;
    endfunction

    // advances like the two registers and holds on a stall.
    always @(posedge i_clk) begin
        if (!i_rst) begin
            exp_stage <= '0;
            exp_out   <= '0;
        end else if (!i_stall) begin
            exp_out   <= exp_stage;
            exp_stage <= i_flush ? '0 : expected_result(i_id_ex);
        end
    end

    // ############################################################
    // checks.
    // ############################################################

    always @(negedge i_clk) begin
        if (!i_rst) begin
            assert (!o_ex_mem.valid && o_ex_mem.mem == '0 && o_ex_mem.wb == '0)
                else report_error("control bits set during reset");
        end
        assert (o_ex_mem === exp_out)
            else report_error($sformatf("o_ex_mem %h, expected %h", o_ex_mem, exp_out));
        if (o_ex_mem.valid) begin
            valid_seen <= valid_seen + 1;
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_rst) i_stall |=> $stable(o_ex_mem))
        else report_error("o_ex_mem changed while stalled");

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    // ############################################################
    // stimulus.
    // ############################################################

    task automatic random_fields(output mips_pkg::id_ex_t instr);
        logic [31:0] r;
        instr = '0;
        r = $random(seed);
        instr.valid = 1'b1;
        instr.pc_next = {r[31:2], 2'b00};
        instr.read_data_1 = $random(seed);
        instr.read_data_2 = $random(seed);
        r = $random(seed);
        instr.imm = {{16{r[15]}}, r[15:0]};
        instr.rt = r[20:16];
        instr.rd = r[25:21];
        instr.mem = r[28:26];
        instr.wb = r[30:29];
    endtask

    task automatic make_rtype(input logic [5:0] funct, output mips_pkg::id_ex_t instr);
        random_fields(instr);
        instr.imm[5:0] = funct;
        instr.ex.reg_dst = 1'b1;
        instr.ex.alu_op = 2'b10;
    endtask

    task automatic make_imm(input logic [1:0] op, output mips_pkg::id_ex_t instr);
        random_fields(instr);
        instr.ex.alu_op = op;
        instr.ex.alu_src = 1'b1;
    endtask

    // branch compares with equal operands about half of the time.
    task automatic make_beq(output mips_pkg::id_ex_t instr);
        logic [31:0] r;
        random_fields(instr);
        r = $random(seed);
        instr.ex.alu_op = 2'b01;
        instr.mem.branch = 1'b1;
        if (r[0]) begin
            instr.read_data_2 = instr.read_data_1;
        end
    endtask

    task automatic make_random(output mips_pkg::id_ex_t instr);
        logic [31:0] r;
        int idx;
        r = $random(seed);
        idx = int'(r[15:0] % 16'd7);
        case (r[18:16])
            3'd0, 3'd1, 3'd2: make_rtype(FUNCT_TABLE[idx], instr);
            3'd3, 3'd4:       make_imm(IMM_OPS[idx % 3], instr);
            3'd5:             make_beq(instr);
            default:          instr = '0;
        endcase
    endtask

    task automatic drive(input mips_pkg::id_ex_t instr, input logic stall, input logic flush);
        @(negedge i_clk);
        i_id_ex = instr;
        i_stall = stall;
        i_flush = flush;
    endtask

    initial begin
        mips_pkg::id_ex_t instr;
        logic [31:0] r;
        logic held;
        seed = 32'h629a;
        i_rst = 1'b0;
        i_stall = 1'b0;
        i_flush = 1'b0;
        i_id_ex = '0;
        held = 1'b0;
        instr = '0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b1;
        for (int f = 0; f < 7; f++) begin
            for (int i = 0; i < N_RTYPE_EACH; i++) begin
                make_rtype(FUNCT_TABLE[f], instr);
                drive(instr, 1'b0, 1'b0);
            end
        end
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < N_IMM_EACH; i++) begin
                make_imm(IMM_OPS[k], instr);
                drive(instr, 1'b0, 1'b0);
            end
        end
        for (int i = 0; i < N_BEQ; i++) begin
            make_beq(instr);
            drive(instr, 1'b0, 1'b0);
        end
        // a stalled instruction is presented again in the random mix.
        for (int i = 0; i < N_MIX; i++) begin
            r = $random(seed);
            if (!held) begin
                make_random(instr);
            end
            drive(instr, r[1:0] == 2'b00, r[4:2] == 3'b000);
            held = (r[1:0] == 2'b00);
        end
        for (int i = 0; i < N_DRAIN; i++) begin
            drive('0, 1'b0, 1'b0);
        end
        @(posedge i_clk);
        assert (valid_seen >= 100)
            else report_error("too few instructions reached the output");
        if (fail_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("** FAIL **");
            $fatal(1, "checks failed");
        end
    end

endmodule

// File: src/ex_core.sv
`timescale 1ns/1ns

module ex_core (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_stall,
    input  logic              i_flush,
    input  mips_pkg::id_ex_t  i_id_ex,
    output mips_pkg::ex_mem_t o_ex_mem
);

    // ############################################################
    // id/ex register.
    // ############################################################

    mips_pkg::id_ex_t  id_ex_q;
    mips_pkg::ex_mem_t ex_mem_d;

    // flush turns the incoming entry into a bubble.
    pipe_reg #(
        .payload_t (mips_pkg::id_ex_t)
    ) id_ex_reg (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_hold  (i_stall),
        .i_clear (i_flush),
        .i_d     (i_id_ex),
        .o_q     (id_ex_q)
    );

    // ############################################################
    // execute.
    // ############################################################

    execute_stage execute_stage_i (
        .i_id_ex  (id_ex_q),
        .o_ex_mem (ex_mem_d)
    );

    // ############################################################
    // ex/mem register.
    // ############################################################

    // keeps advancing on a flush so the bubble moves on.
    pipe_reg #(
        .payload_t (mips_pkg::ex_mem_t)
    ) ex_mem_reg (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_hold  (i_stall),
        .i_clear (1'b0),
        .i_d     (ex_mem_d),
        .o_q     (o_ex_mem)
    );

endmodule

// File: src/pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_hold,
    input  logic     i_clear,
    input  payload_t i_d,
    output payload_t o_q
);

    payload_t q;

    // hold is tested before clear, which loads a bubble.
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            q <= '0;
        end else if (i_hold) begin
            q <= q;
        end else if (i_clear) begin
            q <= '0;
        end else begin
            q <= i_d;
        end
    end

    assign o_q = q;

endmodule

// File: execute/execute_stage.sv
`timescale 1ns/1ns

`include "mips_cfg.svh"

module execute_stage (
    input  mips_pkg::id_ex_t  i_id_ex,
    output mips_pkg::ex_mem_t o_ex_mem
);

    // ############################################################
    // operand and destination selection.
    // ############################################################

    mips_pkg::alu_ctl_e          alu_ctl;
    logic [`MIPS_NB_DATA-1:0]    operand_b;
    logic [`MIPS_NB_DATA-1:0]    alu_result;
    logic                        alu_zero;
    logic [`MIPS_NB_REG-1:0]     write_reg;
    logic [`MIPS_NB_ADDR-1:0]    branch_offset;
    logic [`MIPS_NB_ADDR-1:0]    branch_target;

    always_comb begin
        if (i_id_ex.ex.alu_src) begin
            operand_b = i_id_ex.imm;
        end else begin
            operand_b = i_id_ex.read_data_2;
        end
    end

    // rd for r-type, rt for immediates and loads.
    always_comb begin
        if (i_id_ex.ex.reg_dst) begin
            write_reg = i_id_ex.rd;
        end else begin
            write_reg = i_id_ex.rt;
        end
    end

    // ############################################################
    // branch target.
    // ############################################################

    assign branch_offset = {i_id_ex.imm[`MIPS_NB_ADDR-3:0], 2'b00};
    assign branch_target = i_id_ex.pc_next + branch_offset;

    // ############################################################
    // alu.
    // ############################################################

    alu_control alu_control_i (
        .i_alu_op  (i_id_ex.ex.alu_op),
        .i_funct   (i_id_ex.imm[`MIPS_NB_FUNC-1:0]),
        .o_alu_ctl (alu_ctl)
    );

    alu alu_i (
        .i_alu_ctl (alu_ctl),
        .i_data_a  (i_id_ex.read_data_1),
        .i_data_b  (operand_b),
        .o_result  (alu_result),
        .o_zero    (alu_zero)
    );

    always_comb begin
        o_ex_mem.valid         = i_id_ex.valid;
        o_ex_mem.branch_target = branch_target;
        o_ex_mem.alu_result    = alu_result;
        // a bubble adds zero to zero, so the flag is qualified to keep it all-zero.
        o_ex_mem.zero          = alu_zero & i_id_ex.valid;
        o_ex_mem.store_data    = i_id_ex.read_data_2;
        o_ex_mem.write_reg     = write_reg;
        o_ex_mem.mem           = i_id_ex.mem;
        o_ex_mem.wb            = i_id_ex.wb;
    end

endmodule

// File: execute/alu.sv
`timescale 1ns/1ns

`include "mips_cfg.svh"

module alu (
    input  mips_pkg::alu_ctl_e       i_alu_ctl,
    input  logic [`MIPS_NB_DATA-1:0] i_data_a,
    input  logic [`MIPS_NB_DATA-1:0] i_data_b,
    output logic [`MIPS_NB_DATA-1:0] o_result,
    output logic                     o_zero
);

    logic less_than;

    // signed compare for slt.
    assign less_than = $signed(i_data_a) < $signed(i_data_b);

    always_comb begin
        case (i_alu_ctl)
            mips_pkg::ALU_AND: begin
                o_result = i_data_a & i_data_b;
            end
            mips_pkg::ALU_OR: begin
                o_result = i_data_a | i_data_b;
            end
            mips_pkg::ALU_ADD: begin
                o_result = i_data_a + i_data_b;
            end
            mips_pkg::ALU_SUB: begin
                o_result = i_data_a - i_data_b;
            end
            mips_pkg::ALU_SLT: begin
                o_result = {{(`MIPS_NB_DATA-1){1'b0}}, less_than};
            end
            mips_pkg::ALU_NOR: begin
                o_result = ~(i_data_a | i_data_b);
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

    // used by the branch decision in mem.
    assign o_zero = (o_result == '0);

endmodule

// File: execute/alu_control.sv
`timescale 1ns/1ns

`include "mips_cfg.svh"

module alu_control (
    input  logic [`MIPS_NB_OP-1:0]   i_alu_op,
    input  logic [`MIPS_NB_FUNC-1:0] i_funct,
    output mips_pkg::alu_ctl_e       o_alu_ctl
);

    // r-type function codes.
    localparam logic [`MIPS_NB_FUNC-1:0] FUNCT_ADD = 6'h20;
    localparam logic [`MIPS_NB_FUNC-1:0] FUNCT_SUB = 6'h22;
    localparam logic [`MIPS_NB_FUNC-1:0] FUNCT_AND = 6'h24;
    localparam logic [`MIPS_NB_FUNC-1:0] FUNCT_OR  = 6'h25;
    localparam logic [`MIPS_NB_FUNC-1:0] FUNCT_NOR = 6'h27;
    localparam logic [`MIPS_NB_FUNC-1:0] FUNCT_SLT = 6'h2a;

    mips_pkg::alu_ctl_e funct_ctl;

    // only consulted for op 10.
    always_comb begin
        case (i_funct)
            FUNCT_ADD: funct_ctl = mips_pkg::ALU_ADD;
            FUNCT_SUB: funct_ctl = mips_pkg::ALU_SUB;
            FUNCT_AND: funct_ctl = mips_pkg::ALU_AND;
            FUNCT_OR:  funct_ctl = mips_pkg::ALU_OR;
            FUNCT_NOR: funct_ctl = mips_pkg::ALU_NOR;
            FUNCT_SLT: funct_ctl = mips_pkg::ALU_SLT;
            default:   funct_ctl = mips_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        case (i_alu_op)
            // loads and stores compute an address.
            2'b00:   o_alu_ctl = mips_pkg::ALU_ADD;
            // beq compares by subtraction.
            2'b01:   o_alu_ctl = mips_pkg::ALU_SUB;
            2'b10:   o_alu_ctl = funct_ctl;
            // slti.
            default: o_alu_ctl = mips_pkg::ALU_SLT;
        endcase
    end

endmodule

// File: common/mips_pkg.sv
`include "mips_cfg.svh"

package mips_pkg;

    // ############################################################
    // control bundles, in the order the decoder packs them.
    // ############################################################

    typedef struct packed {
        logic                     reg_dst;
        logic [`MIPS_NB_OP-1:0]   alu_op;
        logic                     alu_src;
    } ex_ctrl_t;

    typedef struct packed {
        logic branch;
        logic mem_read;
        logic mem_write;
    } mem_ctrl_t;

    typedef struct packed {
        logic reg_write;
        logic mem_to_reg;
    } wb_ctrl_t;

    typedef enum logic [3:0] {
        ALU_AND = 4'b0000,
        ALU_OR  = 4'b0001,
        ALU_ADD = 4'b0010,
        ALU_SUB = 4'b0110,
        ALU_SLT = 4'b0111,
        ALU_NOR = 4'b1100
    } alu_ctl_e;

    // ############################################################
    // pipeline register payloads.
    // ############################################################

    typedef struct packed {
        logic                       valid;
        logic [`MIPS_NB_ADDR-1:0]   pc_next;
        logic [`MIPS_NB_DATA-1:0]   read_data_1;
        logic [`MIPS_NB_DATA-1:0]   read_data_2;
        logic [`MIPS_NB_DATA-1:0]   imm;
        logic [`MIPS_NB_REG-1:0]    rt;
        logic [`MIPS_NB_REG-1:0]    rd;
        ex_ctrl_t                   ex;
        mem_ctrl_t                  mem;
        wb_ctrl_t                   wb;
    } id_ex_t;

    typedef struct packed {
        logic                       valid;
        logic [`MIPS_NB_ADDR-1:0]   branch_target;
        logic [`MIPS_NB_DATA-1:0]   alu_result;
        logic                       zero;
        logic [`MIPS_NB_DATA-1:0]   store_data;
        logic [`MIPS_NB_REG-1:0]    write_reg;
        mem_ctrl_t                  mem;
        wb_ctrl_t                   wb;
    } ex_mem_t;

endpackage

// File: common/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// ############################################################
// datapath widths.
// ############################################################

// data and alu width.
`define MIPS_NB_DATA 32

// program counter width.
`define MIPS_NB_ADDR 32

// register index width.
`define MIPS_NB_REG 5

// alu op from the main decoder.
`define MIPS_NB_OP 2

// function field of r-type instructions.
`define MIPS_NB_FUNC 6

`endif
